/* rtl/pocket_core_pkg.sv */
// shared types and constants for the core top
// bridge register map, adapter config fields, pad words and video structs
// every rtl module pulls this in with a wildcard import

package pocket_core_pkg;

    //////////////////////////////////////////////////////////////////////
    // bridge bus
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    localparam bridge_addr_t ADDR_RESET       = 32'hF000_0000; // bit 0 = core reset switch
    localparam bridge_addr_t ADDR_MODS        = 32'hF200_0000; // bit 0 = adapter enable
    localparam bridge_addr_t ADDR_ADAPTER_CFG = 32'hF700_0000; // adapter config word

    //////////////////////////////////////////////////////////////////////
    // adapter configuration
    //////////////////////////////////////////////////////////////////////

    typedef logic [4:0] snac_type_t;

    localparam snac_type_t SNAC_NONE     = 5'h00;
    localparam snac_type_t SNAC_ANALOG_A = 5'h12; // analog pad, left stick drives d-pad
    localparam snac_type_t SNAC_ANALOG_B = 5'h13;

    // which adapter pad lands on which player
    typedef enum logic [1:0] {
        ASSIGN_P1_TO_P1 = 2'd0,
        ASSIGN_P1_TO_P2 = 2'd1,
        ASSIGN_BOTH     = 2'd2,
        ASSIGN_SWAPPED  = 2'd3
    } snac_assign_t;

    typedef struct packed {
        snac_type_t   cont_type;    // word bits 4:0
        snac_assign_t cont_assign;  // word bits 9:8
        logic         blank_screen; // word bit 12
    } adapter_cfg_t;

    //////////////////////////////////////////////////////////////////////
    // controller pads
    //////////////////////////////////////////////////////////////////////

    typedef logic [15:0] pad_keys_t;  // 0 up, 1 down, 2 left, 3 right ... 15 start
    typedef logic [31:0] pad_stick_t; // 7:0 lstick x, 15:8 lstick y
    typedef logic [7:0]  stick_axis_t;

    typedef struct packed {
        pad_keys_t  keys;
        pad_stick_t stick;
    } pad_state_t;

    // dead zone, values at the threshold count as idle
    localparam stick_axis_t STICK_LOW  = 8'h40;
    localparam stick_axis_t STICK_HIGH = 8'hC0;

    //////////////////////////////////////////////////////////////////////
    // video
    //////////////////////////////////////////////////////////////////////

    typedef logic [23:0] rgb_t; // red in 23:16

    typedef struct packed {
        logic hs;
        logic vs;
        logic hblank;
        logic vblank;
    } video_sync_t;

endpackage

/* rtl/bridge_regs.sv */
// host bridge register block
// holds core reset switch, adapter enable and adapter config word
// writes land next cycle, reads return registered data one cycle after the strobe

module bridge_regs
    import pocket_core_pkg::*;
(
    input  logic         clk_74a,
    input  logic         rst,
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_wr,
    input  bridge_data_t bridge_wr_data,
    input  logic         bridge_rd,
    output bridge_data_t bridge_rd_data,
    output logic         core_reset,
    output logic         adapter_en,
    output adapter_cfg_t cfg
);

    logic         reset_sw;  // ADDR_RESET bit 0
    logic         mods_en;   // ADDR_MODS bit 0
    bridge_data_t cfg_word;  // raw config word as written by host

    //////////////////////////////////////////////////////////////////////
    // write decode
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            reset_sw <= 1'b0;
            mods_en  <= 1'b0;
            cfg_word <= '0;
        end else if (bridge_wr) begin
            // exact match only, no mirroring
            case (bridge_addr)
                ADDR_RESET:       reset_sw <= bridge_wr_data[0];
                ADDR_MODS:        mods_en  <= bridge_wr_data[0];
                ADDR_ADAPTER_CFG: cfg_word <= bridge_wr_data;
                default: ;        // unmapped, dropped
            endcase
        end
    end

    assign core_reset = reset_sw;
    assign adapter_en = mods_en;

    // config fields pulled out of the raw word
    assign cfg.cont_type    = snac_type_t'(cfg_word[4:0]);
    assign cfg.cont_assign  = snac_assign_t'(cfg_word[9:8]);
    assign cfg.blank_screen = cfg_word[12];

    //////////////////////////////////////////////////////////////////////
    // read back
    //////////////////////////////////////////////////////////////////////

    // data held until the next read strobe
    always_ff @(posedge clk_74a) begin
        if (rst) begin
            bridge_rd_data <= '0;
        end else if (bridge_rd) begin
            case (bridge_addr)
                ADDR_RESET:       bridge_rd_data <= {31'd0, reset_sw}; // upper bits zero
                ADDR_MODS:        bridge_rd_data <= {31'd0, mods_en};
                ADDR_ADAPTER_CFG: bridge_rd_data <= cfg_word;
                default:          bridge_rd_data <= '0;
            endcase
        end
    end

endmodule

/* rtl/controller_router.sv */
// player input router
// picks handheld pads or adapter pads per player from the adapter config
// analog adapter types get their d-pad from the left stick
// outputs registered one cycle after any input change

module controller_router
    import pocket_core_pkg::*;
(
    input  logic         clk_74a,
    input  logic         rst,
    input  logic         adapter_en,
    input  adapter_cfg_t cfg,
    input  pad_keys_t    pocket_p1,
    input  pad_keys_t    pocket_p2,
    input  pad_state_t   snac_p1,
    input  pad_state_t   snac_p2,
    output pad_keys_t    p1_keys,
    output pad_keys_t    p2_keys
);

    logic      snac_is_analog;
    logic      snac_active;
    pad_keys_t snac_p1_eff;  // adapter p1 after stick conversion
    pad_keys_t snac_p2_eff;
    pad_keys_t p1_next;
    pad_keys_t p2_next;

    // stick to d-pad with strict thresholds so the edge values stay idle
    function automatic pad_keys_t stick_to_keys(input pad_state_t pad, input logic analog);
        stick_axis_t sx;
        stick_axis_t sy;
        pad_keys_t   k;
        sx = pad.stick[7:0];
        sy = pad.stick[15:8];
        k  = pad.keys;
        if (analog) begin
            k[0] = (sy < STICK_LOW);   // up
            k[1] = (sy > STICK_HIGH);  // down
            k[2] = (sx < STICK_LOW);   // left
            k[3] = (sx > STICK_HIGH);  // right
        end
        return k;
    endfunction

    assign snac_is_analog = (cfg.cont_type == SNAC_ANALOG_A) ||
                            (cfg.cont_type == SNAC_ANALOG_B);

    // adapter only counts when enabled and a type is set
    assign snac_active = adapter_en && (cfg.cont_type != SNAC_NONE);

    assign snac_p1_eff = stick_to_keys(snac_p1, snac_is_analog);
    assign snac_p2_eff = stick_to_keys(snac_p2, snac_is_analog);

    //////////////////////////////////////////////////////////////////////
    // player source select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        p1_next = pocket_p1;  // pass-through by default
        p2_next = pocket_p2;
        if (snac_active) begin
            case (cfg.cont_assign)
                ASSIGN_P1_TO_P1: begin
                    p1_next = snac_p1_eff;
                    p2_next = pocket_p1;     // handheld moves over to p2
                end
                ASSIGN_P1_TO_P2: begin
                    p1_next = pocket_p1;
                    p2_next = snac_p1.keys;  // raw keys without stick mapping
                end
                ASSIGN_BOTH: begin
                    p1_next = snac_p1_eff;
                    p2_next = snac_p2_eff;
                end
                ASSIGN_SWAPPED: begin
                    p1_next = snac_p2_eff;
                    p2_next = snac_p1_eff;
                end
            endcase
        end
    end

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            p1_keys <= '0;
            p2_keys <= '0;
        end else begin
            p1_keys <= p1_next;
            p2_keys <= p2_next;
        end
    end

endmodule

/* rtl/video_timing.sv */
// progressive raster timing
// pix_ce pulses once every PIX_DIV clocks, x/y counters step on it
// sync and blank are decoded straight from the counters

module video_timing
    import pocket_core_pkg::*;
#(
    parameter int PIX_DIV  = 12,
    parameter int H_ACTIVE = 320,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 32,
    parameter int H_TOTAL  = 400,
    parameter int V_ACTIVE = 240,
    parameter int V_FRONT  = 4,
    parameter int V_TOTAL  = 262
) (
    input  logic        clk_74a,
    input  logic        rst,
    output logic        pix_ce,
    output video_sync_t sync
);

    localparam int DW = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
    localparam int XW = $clog2(H_TOTAL);
    localparam int YW = $clog2(V_TOTAL);

    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_LINE  = V_ACTIVE + V_FRONT;

    logic [DW-1:0] div_cnt;
    logic [XW-1:0] x_cnt;
    logic [YW-1:0] y_cnt;

    //////////////////////////////////////////////////////////////////////
    // pixel enable divider
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (div_cnt == DW'(PIX_DIV - 1)) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign pix_ce = (div_cnt == DW'(PIX_DIV - 1)); // last clock of the pixel

    //////////////////////////////////////////////////////////////////////
    // raster counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (pix_ce) begin
            if (x_cnt == XW'(H_TOTAL - 1)) begin
                x_cnt <= '0;
                // end of line, step or wrap y
                if (y_cnt == YW'(V_TOTAL - 1)) begin
                    y_cnt <= '0;
                end else begin
                    y_cnt <= y_cnt + 1'b1;
                end
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    // decode, active area first then porch/sync
    assign sync.hblank = (x_cnt >= XW'(H_ACTIVE));
    assign sync.vblank = (y_cnt >= YW'(V_ACTIVE));
    assign sync.hs     = (x_cnt >= XW'(H_SYNC_START)) &&
                         (x_cnt <  XW'(H_SYNC_START + H_SYNC));
    assign sync.vs     = (y_cnt == YW'(V_SYNC_LINE)); // one full line

endmodule

/* rtl/video_out.sv */
// video output stage
// registers syncs and pixel on pix_ce, forces black outside active area
// blank_screen comes in already qualified with the adapter enable

module video_out
    import pocket_core_pkg::*;
(
    input  logic        clk_74a,
    input  logic        rst,
    input  logic        pix_ce,
    input  video_sync_t sync,
    input  rgb_t        pixel,
    input  logic        blank_screen,
    output rgb_t        video_rgb,
    output logic        video_de,
    output logic        video_hs,
    output logic        video_vs
);

    rgb_t pixel_q;  // sampled core pixel

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            video_de <= 1'b0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
        end else if (pix_ce) begin
            video_de <= ~(sync.hblank | sync.vblank);
            video_hs <= sync.hs;
            video_vs <= sync.vs;
        end
    end

    always_ff @(posedge clk_74a) begin
        if (pix_ce) begin
            pixel_q <= pixel;
        end
    end

    // black in blanking and when the handheld screen is switched off
    assign video_rgb = (video_de && !blank_screen) ? pixel_q : '0;

endmodule

/* rtl/core_top.sv */
// core top level
// bridge registers, controller routing and the video path on clk_74a
// video parameters default to a 320x240 raster and are passed down

module core_top
    import pocket_core_pkg::*;
#(
    parameter int PIX_DIV  = 12,
    parameter int H_ACTIVE = 320,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 32,
    parameter int H_TOTAL  = 400,
    parameter int V_ACTIVE = 240,
    parameter int V_FRONT  = 4,
    parameter int V_TOTAL  = 262
) (
    input  logic         clk_74a,
    input  logic         rst,
    // bridge bus
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_wr,
    input  bridge_data_t bridge_wr_data,
    input  logic         bridge_rd,
    output bridge_data_t bridge_rd_data,
    // controllers
    input  pad_keys_t    pocket_p1,
    input  pad_keys_t    pocket_p2,
    input  pad_state_t   snac_p1,
    input  pad_state_t   snac_p2,
    output pad_keys_t    p1_keys,
    output pad_keys_t    p2_keys,
    // video
    input  rgb_t         core_pixel,
    output rgb_t         video_rgb,
    output logic         video_de,
    output logic         video_hs,
    output logic         video_vs
);

    logic         core_reset;
    logic         adapter_en;
    adapter_cfg_t cfg;
    logic         video_rst;   // system reset or host reset switch
    logic         pix_ce;
    video_sync_t  sync;

    bridge_regs u_bridge_regs (
        .clk_74a        (clk_74a),
        .rst            (rst),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .core_reset     (core_reset),
        .adapter_en     (adapter_en),
        .cfg            (cfg)
    );

    controller_router u_controller_router (
        .clk_74a    (clk_74a),
        .rst        (rst),
        .adapter_en (adapter_en),
        .cfg        (cfg),
        .pocket_p1  (pocket_p1),
        .pocket_p2  (pocket_p2),
        .snac_p1    (snac_p1),
        .snac_p2    (snac_p2),
        .p1_keys    (p1_keys),
        .p2_keys    (p2_keys)
    );

    //////////////////////////////////////////////////////////////////////
    // video path, held in reset while the host switch is set
    //////////////////////////////////////////////////////////////////////

    assign video_rst = rst | core_reset;

    video_timing #(
        .PIX_DIV  (PIX_DIV),
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_TOTAL  (V_TOTAL)
    ) u_video_timing (
        .clk_74a (clk_74a),
        .rst     (video_rst),
        .pix_ce  (pix_ce),
        .sync    (sync)
    );

    video_out u_video_out (
        .clk_74a      (clk_74a),
        .rst          (video_rst),
        .pix_ce       (pix_ce),
        .sync         (sync),
        .pixel        (core_pixel),
        .blank_screen (adapter_en & cfg.blank_screen), // only with adapter on
        .video_rgb    (video_rgb),
        .video_de     (video_de),
        .video_hs     (video_hs),
        .video_vs     (video_vs)
    );

endmodule

/* test/tb_vectors.svh */
// controller routing table for tb_core_top
// one row per case: bridge words, pad inputs and the expected player keys
// included inside the testbench module, filled once at time zero

typedef struct packed {
    logic         rand_stick;  // sticks drawn at run time, row uses ASSIGN_BOTH
    bridge_data_t mods;        // ADDR_MODS word
    bridge_data_t cfg;         // ADDR_ADAPTER_CFG word
    pad_keys_t    pocket_p1;
    pad_keys_t    pocket_p2;
    pad_keys_t    snac1_keys;
    pad_stick_t   snac1_stick; // y in 15:8, x in 7:0
    pad_keys_t    snac2_keys;
    pad_stick_t   snac2_stick;
    pad_keys_t    exp_p1;
    pad_keys_t    exp_p2;
} vector_t;

vector_t vectors[$];
string   vector_names[$];

task automatic add_vector(input string name, input vector_t row);
    vectors.push_back(row);
    vector_names.push_back(name);
endtask

task automatic build_vector_table();
    // columns: rand, mods, cfg, pocket p1, pocket p2,
    //          snac1 keys, snac1 stick, snac2 keys, snac2 stick, exp p1, exp p2

    // adapter off or no type, handheld pads pass straight through
    add_vector("off_both", vector_t'{1'b0, 32'h0, 32'h0202, 16'h1111, 16'h2222,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h00FF, 16'h1111, 16'h2222});
    add_vector("off_analog", vector_t'{1'b0, 32'h0, 32'h0312, 16'h8001, 16'h4002,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h00FF, 16'h8001, 16'h4002});
    add_vector("none_p1p1", vector_t'{1'b0, 32'h1, 32'h0000, 16'h1111, 16'h2222,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h00FF, 16'h1111, 16'h2222});
    add_vector("none_p1p2", vector_t'{1'b0, 32'h1, 32'h0100, 16'h1111, 16'h2222,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h00FF, 16'h1111, 16'h2222});
    add_vector("none_both", vector_t'{1'b0, 32'h1, 32'h0200, 16'h1111, 16'h2222,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h00FF, 16'h1111, 16'h2222});
    add_vector("none_swap", vector_t'{1'b0, 32'h1, 32'h0300, 16'h8001, 16'h4002,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h00FF, 16'h8001, 16'h4002});

    // digital type 0x02, stick ignored
    add_vector("dig_p1p1", vector_t'{1'b0, 32'h1, 32'h0002, 16'h1111, 16'h2222,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h00FF, 16'hA5C3, 16'h1111});
    add_vector("dig_p1p2", vector_t'{1'b0, 32'h1, 32'h0102, 16'h1111, 16'h2222,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h00FF, 16'h1111, 16'hA5C3});
    add_vector("dig_both", vector_t'{1'b0, 32'h1, 32'h0202, 16'h1111, 16'h2222,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h00FF, 16'hA5C3, 16'h5A3C});
    add_vector("dig_swap", vector_t'{1'b0, 32'h1, 32'h0302, 16'h1111, 16'h2222,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h00FF, 16'h5A3C, 16'hA5C3});

    // analog types, 0x40 and 0xC0 sit in the dead zone
    add_vector("ana_a_edges", vector_t'{1'b0, 32'h1, 32'h0212, 16'h1111, 16'h2222,
        16'hA5C3, 32'h40C0, 16'h5A3C, 32'h3FC1, 16'hA5C0, 16'h5A39});
    add_vector("ana_b_edges", vector_t'{1'b0, 32'h1, 32'h0213, 16'h1111, 16'h2222,
        16'hA5C3, 32'hC13F, 16'h5A3C, 32'hC040, 16'hA5C6, 16'h5A30});
    add_vector("ana_a_p1p1", vector_t'{1'b0, 32'h1, 32'h0012, 16'h1111, 16'h2222,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h8080, 16'hA5C9, 16'h1111});
    add_vector("ana_a_p1p2", vector_t'{1'b0, 32'h1, 32'h0112, 16'h1111, 16'h2222,
        16'hA5C3, 32'h00FF, 16'h5A3C, 32'h8080, 16'h1111, 16'hA5C3}); // raw keys on p2
    add_vector("ana_b_swap", vector_t'{1'b0, 32'h1, 32'h0313, 16'h1111, 16'h2222,
        16'hA5C3, 32'h8080, 16'h5A3C, 32'hFF00, 16'h5A36, 16'hA5C0});

    // random sticks, expected d-pad worked out in the loop
    add_vector("ana_a_rand0", vector_t'{1'b1, 32'h1, 32'h0212, 16'h1111, 16'h2222,
        16'hA5C3, 32'h0, 16'h5A3C, 32'h0, 16'h0, 16'h0});
    add_vector("ana_b_rand1", vector_t'{1'b1, 32'h1, 32'h0213, 16'h1111, 16'h2222,
        16'hFFFF, 32'h0, 16'h0000, 32'h0, 16'h0, 16'h0});
    add_vector("ana_b_rand2", vector_t'{1'b1, 32'h1, 32'h0213, 16'h1111, 16'h2222,
        16'h8000, 32'h0, 16'h7FF0, 32'h0, 16'h0, 16'h0});
endtask

/* test/tb_core_top.sv */
// testbench for core_top
// bridge read-back, controller routing table, video counts, core reset switch
// small raster so a frame is only a few hundred clocks

module tb_core_top
    import pocket_core_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PIX_DIV  = 2;
    localparam int H_ACTIVE = 8;
    localparam int H_FRONT  = 1;
    localparam int H_SYNC   = 2;
    localparam int H_TOTAL  = 12;
    localparam int V_ACTIVE = 4;
    localparam int V_FRONT  = 1;
    localparam int V_TOTAL  = 6;

    localparam int FRAME_CLKS   = PIX_DIV * H_TOTAL * V_TOTAL;
    localparam int VIDEO_FRAMES = 6;  // frames spent in the video checks

    logic         clk_74a;
    logic         rst;
    bridge_addr_t bridge_addr;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    logic         bridge_rd;
    bridge_data_t bridge_rd_data;
    pad_keys_t    pocket_p1;
    pad_keys_t    pocket_p2;
    pad_state_t   snac_p1;
    pad_state_t   snac_p2;
    pad_keys_t    p1_keys;
    pad_keys_t    p2_keys;
    rgb_t         core_pixel;
    rgb_t         video_rgb;
    logic         video_de;
    logic         video_hs;
    logic         video_vs;

    int     errors;
    integer seed;

    `include "tb_vectors.svh"

    core_top #(
        .PIX_DIV (PIX_DIV), .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC),
        .H_TOTAL (H_TOTAL), .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_TOTAL (V_TOTAL)
    ) u_core_top (.*);

    initial begin
        clk_74a = 1'b0;
        forever #5 clk_74a = ~clk_74a;  // 100 MHz stand-in for the 74.25 MHz clock
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // called 1 ns after an edge so the strobe lands on the next one
    task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(posedge clk_74a);
        #1;
        bridge_wr      = 1'b0;
    endtask

    task automatic read_expect(input string name, input bridge_addr_t addr,
                               input bridge_data_t expected);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(posedge clk_74a);
        #1;
        bridge_rd   = 1'b0;
        check_value(name, expected, bridge_rd_data);  // registered on the strobe edge
    endtask

    // bit order right, left, down, up
    function automatic logic [3:0] stick_dpad(input pad_stick_t stick);
        logic [7:0] sx;
        logic [7:0] sy;
        sx = stick[7:0];
        sy = stick[15:8];
        return {sx > STICK_HIGH, sx < STICK_LOW, sy > STICK_HIGH, sy < STICK_LOW};
    endfunction

    // one sample per pixel over a full frame covers every pixel once at any phase
    task automatic check_frame(input string name, input logic blanked, input int exp_de,
                               input int exp_hs, input int exp_vs);
        int   de_cnt;
        int   hs_cnt;
        int   vs_cnt;
        rgb_t exp_rgb;
        de_cnt = 0;
        hs_cnt = 0;
        vs_cnt = 0;
        repeat (H_TOTAL * V_TOTAL) begin
            repeat (PIX_DIV) @(posedge clk_74a);
            #1;
            if (video_de) de_cnt++;
            if (video_hs) hs_cnt++;
            if (video_vs) vs_cnt++;
            exp_rgb = (video_de && !blanked) ? core_pixel : '0;  // black off screen
            check_value({name, " rgb"}, 32'(exp_rgb), 32'(video_rgb));
        end
        check_value({name, " de count"}, exp_de, de_cnt);
        check_value({name, " hs count"}, exp_hs, hs_cnt);
        check_value({name, " vs count"}, exp_vs, vs_cnt);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        vector_t   v;
        pad_keys_t exp_p1;
        pad_keys_t exp_p2;
        errors         = 0;
        seed           = 32'h1dde;
        rst            = 1'b1;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        bridge_rd      = 1'b0;
        pocket_p1      = 16'h1111;  // live pads while in reset
        pocket_p2      = 16'h2222;
        snac_p1        = '0;
        snac_p2        = '0;
        core_pixel     = 24'hC0FFEE;
        build_vector_table();
        repeat (10) @(posedge clk_74a);
        #1;
        rst = 1'b0;

        check_value("reset p1_keys", 32'h0, 32'(p1_keys));
        check_value("reset p2_keys", 32'h0, 32'(p2_keys));
        check_value("reset video", 32'h0, 32'({video_de, video_hs, video_vs}));

        // bridge read-back with the unmapped read after a nonzero one
        bridge_write(ADDR_MODS, 32'hFFFF_FFFF);
        read_expect("mods readback", ADDR_MODS, 32'h1);
        bridge_write(ADDR_ADAPTER_CFG, 32'hA5A5_0213);
        read_expect("cfg readback", ADDR_ADAPTER_CFG, 32'hA5A5_0213);
        read_expect("unmapped readback", 32'hF100_0000, 32'h0);

        // core reset switch holds the video path quiet
        bridge_write(ADDR_RESET, 32'h0000_0003);
        read_expect("reset readback", ADDR_RESET, 32'h1);
        check_frame("core reset held", 1'b0, 0, 0, 0);
        bridge_write(ADDR_RESET, 32'h0);
        read_expect("reset cleared", ADDR_RESET, 32'h0);
        repeat (4) @(posedge clk_74a);
        #1;
        check_frame("after core reset", 1'b0, H_ACTIVE * V_ACTIVE, H_SYNC * V_TOTAL, H_TOTAL);

        // controller table
        foreach (vectors[i]) begin
            v = vectors[i];
            bridge_write(ADDR_MODS, v.mods);
            bridge_write(ADDR_ADAPTER_CFG, v.cfg);
            pocket_p1     = v.pocket_p1;
            pocket_p2     = v.pocket_p2;
            snac_p1.keys  = v.snac1_keys;
            snac_p2.keys  = v.snac2_keys;
            snac_p1.stick = v.snac1_stick;
            snac_p2.stick = v.snac2_stick;
            exp_p1        = v.exp_p1;
            exp_p2        = v.exp_p2;
            if (v.rand_stick) begin
                snac_p1.stick = $random(seed);
                snac_p2.stick = $random(seed);
                exp_p1        = {v.snac1_keys[15:4], stick_dpad(snac_p1.stick)};
                exp_p2        = {v.snac2_keys[15:4], stick_dpad(snac_p2.stick)};
            end
            repeat (2) @(posedge clk_74a);
            #1;
            check_value({vector_names[i], " p1"}, 32'(exp_p1), 32'(p1_keys));
            check_value({vector_names[i], " p2"}, 32'(exp_p2), 32'(p2_keys));
        end

        // video with constant pixel and then screen blank via adapter config
        core_pixel = 24'h3C96E1;
        bridge_write(ADDR_MODS, 32'h1);
        bridge_write(ADDR_ADAPTER_CFG, 32'h0);
        check_frame("frame 0", 1'b0, H_ACTIVE * V_ACTIVE, H_SYNC * V_TOTAL, H_TOTAL);
        check_frame("frame 1", 1'b0, H_ACTIVE * V_ACTIVE, H_SYNC * V_TOTAL, H_TOTAL);
        bridge_write(ADDR_ADAPTER_CFG, 32'h0000_1000);
        check_frame("screen blank", 1'b1, H_ACTIVE * V_ACTIVE, H_SYNC * V_TOTAL, H_TOTAL);
        bridge_write(ADDR_MODS, 32'h0);  // blank bit ignored with adapter off
        check_frame("adapter off", 1'b0, H_ACTIVE * V_ACTIVE, H_SYNC * V_TOTAL, H_TOTAL);

        $display("tb_core_top done: %0d errors over %0d vectors", errors, vectors.size());
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog budget from table length plus video frames
    initial begin
        int limit;
        #1;
        limit = 10 + vectors.size() * 20 + (VIDEO_FRAMES + 3) * FRAME_CLKS;
        repeat (limit) @(posedge clk_74a);
        $display("timeout: the tests did not finish within %0d clock cycles", limit);
        $display("Something failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+test
rtl/pocket_core_pkg.sv
rtl/bridge_regs.sv
rtl/controller_router.sv
rtl/video_timing.sv
rtl/video_out.sv
rtl/core_top.sv
test/tb_core_top.sv

/* run.sh */
#!/usr/bin/env bash
# builds tb_core_top with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timescale 1ns/100ps -f verilog.f --top-module tb_core_top -o tb_core_top &&
./obj_dir/tb_core_top | tee /dev/stderr | grep -q "^Everything OK$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
